// ==== flist.f ====
if_pkg.sv
axi_lite_pkg.sv
pc_target_sel.sv
resp_fifo.sv
fetch_unit.sv
if_id_pipe.sv
if_stage_top.sv
tb_axi_mem.sv
tb_if_stage.sv

// ==== Makefile ====
# Verilator build and run of the fetch stage testbench

SRCS = $(shell cat flist.f)

obj_dir/Vtb_if_stage: $(SRCS) flist.f
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	  --top-module tb_if_stage -f flist.f

run: obj_dir/Vtb_if_stage
	./obj_dir/Vtb_if_stage > sim.log 2>&1; cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== tb_if_stage.sv ====
/*
  Table-driven testbench of the instruction fetch stage
  Each row redirects the stage and collects a number of IF/ID captures
  Expected PCs, words and flags follow the memory address rules
  The controller kills IF in every redirect cycle
*/
`timescale 1ns/10ps

module tb_if_stage;

  import if_pkg::*;
  import axi_lite_pkg::*;

  localparam int unsigned NUM_STIM   = 15;
  localparam logic [31:0] MTVEC_ADDR = 32'h0000_1000;
  localparam logic [31:0] MTVT_ADDR  = 32'h0000_4000;
  // Value of every target field not selected by the row
  localparam logic [31:0] DECOY_ADDR = 32'h0000_7000;

  // One redirect and the words expected after it
  typedef struct packed {
    pc_mux_e     pc_mux;
    logic [4:0]  mtvec_idx;
    logic [3:0]  mtvt_idx;
    logic [31:0] tgt;
    logic [7:0]  n_words;
    // id_ready duty, one bit per cycle, zero for random
    logic [7:0]  ready_pat;
  } stim_t;

  stim_t stim [NUM_STIM] = '{
    '{BOOT,       5'd0, 4'd0,  32'h0000_0102, 8'd8,  8'hFF},
    '{JUMP,       5'd0, 4'd0,  32'h0000_0200, 8'd3,  8'hFF},
    '{BRANCH,     5'd0, 4'd0,  32'h0000_0300, 8'd4,  8'hB6},
    '{MRET,       5'd0, 4'd0,  32'h0000_0400, 8'd3,  8'hFF},
    '{DRET,       5'd0, 4'd0,  32'h0000_0500, 8'd3,  8'hAA},
    '{TRAP_EXC,   5'd3, 4'd0,  32'h0000_0000, 8'd3,  8'hFF},
    '{TRAP_IRQ,   5'd5, 4'd0,  32'h0000_0000, 8'd3,  8'hFF},
    '{TRAP_NMI,   5'd9, 4'd0,  32'h0000_0000, 8'd3,  8'hFF},
    '{TRAP_DBD,   5'd0, 4'd0,  32'h0000_0803, 8'd3,  8'hFF},
    '{TRAP_DBE,   5'd0, 4'd0,  32'h0000_0902, 8'd3,  8'hFF},
    '{BRANCH,     5'd0, 4'd0,  32'h0000_3000, 8'd4,  8'h00},
    '{JUMP,       5'd0, 4'd0,  32'h0000_0600, 8'd16, 8'h00},
    '{TRAP_CLICV, 5'd0, 4'd15, 32'h0000_0000, 8'd1,  8'hFF},
    '{POINTER,    5'd0, 4'd0,  32'h0000_0000, 8'd6,  8'h00},
    '{BOOT,       5'd0, 4'd0,  32'h0000_0100, 8'd2,  8'hFF}
  };

  logic        clk = 1'b0;
  logic        rst_n;
  ctrl_fsm_t   ctrl;
  pc_targets_t targets;
  axi_ar_t     ar;
  logic        arvalid;
  logic        arready;
  axi_r_t      r;
  logic        rvalid;
  logic        rready;
  logic        id_ready;
  logic        if_valid;
  if_id_pipe_t pipe;
  logic [31:0] pc_if;
  logic        mtvec_init;
  logic        busy;

  integer      seed = 32'h67d50821;
  int          errors = 0;
  int          checks = 0;
  int          busy_redirects = 0;
  // Vector table index of the last CLIC pointer fetch
  logic [3:0]  ptr_idx = '0;

  always #10 clk = ~clk;

  if_stage_top dut (
    .clk          ( clk        ),
    .rst_n        ( rst_n      ),
    .ctrl_i       ( ctrl       ),
    .targets_i    ( targets    ),
    .ar_o         ( ar         ),
    .arvalid_o    ( arvalid    ),
    .arready_i    ( arready    ),
    .r_i          ( r          ),
    .rvalid_i     ( rvalid     ),
    .rready_o     ( rready     ),
    .id_ready_i   ( id_ready   ),
    .if_valid_o   ( if_valid   ),
    .pipe_o       ( pipe       ),
    .pc_if_o      ( pc_if      ),
    .mtvec_init_o ( mtvec_init ),
    .busy_o       ( busy       )
  );

  tb_axi_mem #(.SEED(32'h67d50821)) mem (
    .clk       ( clk     ),
    .rst_n     ( rst_n   ),
    .ar_i      ( ar      ),
    .arvalid_i ( arvalid ),
    .arready_o ( arready ),
    .r_o       ( r       ),
    .rvalid_o  ( rvalid  ),
    .rready_i  ( rready  )
  );

  //////////////////////////////////////////////////////////////////////////
  // Expected values
  //////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] exp_word(logic [31:0] a);
    logic [31:0] w;
    w = a ^ 32'h5A5A_0003;
    if (a >= 32'h0000_3000 && a < 32'h0000_3100) begin
      w = '0;
    end else if (a == 32'h0000_2100) begin
      w[15:0] = 16'h0000;
    end else if (a >= 32'h0000_2000 && a < 32'h0000_3000) begin
      w[1:0] = 2'b01;
    end
    return w;
  endfunction

  // First captured PC after the redirect of a row
  function automatic logic [31:0] first_pc(stim_t s);
    case (s.pc_mux)
      TRAP_EXC:   return MTVEC_ADDR;
      TRAP_IRQ:   return MTVEC_ADDR + {25'd0, s.mtvec_idx, 2'b00};
      TRAP_NMI:   return MTVEC_ADDR + 32'd60;
      TRAP_CLICV: return MTVT_ADDR + {26'd0, s.mtvt_idx, 2'b00};
      POINTER:    return 32'h0000_2000 + {24'd0, ptr_idx, 4'h0};
      default:    return {s.tgt[31:2], 2'b00};
    endcase
  endfunction

  function automatic ctrl_fsm_t make_ctrl(stim_t s, logic set);
    ctrl_fsm_t c;
    c.pc_set    = set;
    c.pc_mux    = s.pc_mux;
    c.kill_if   = set;
    c.halt_if   = 1'b0;
    c.mtvec_idx = s.mtvec_idx;
    c.mtvt_idx  = s.mtvt_idx;
    return c;
  endfunction

  function automatic pc_targets_t make_targets(stim_t s);
    pc_targets_t t;
    t.boot    = DECOY_ADDR;
    t.jump    = DECOY_ADDR;
    t.branch  = DECOY_ADDR;
    t.mepc    = DECOY_ADDR;
    t.dpc     = DECOY_ADDR;
    t.dm_halt = DECOY_ADDR;
    t.dm_exc  = DECOY_ADDR;
    t.mtvec   = MTVEC_ADDR[31:7];
    t.mtvt    = MTVT_ADDR[31:6];
    case (s.pc_mux)
      BOOT:     t.boot    = s.tgt;
      JUMP:     t.jump    = s.tgt;
      BRANCH:   t.branch  = s.tgt;
      MRET:     t.mepc    = s.tgt;
      DRET:     t.dpc     = s.tgt;
      TRAP_DBD: t.dm_halt = s.tgt;
      TRAP_DBE: t.dm_exc  = s.tgt;
      default:  ;
    endcase
    return t;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [103:0] got,
                               input logic [103:0] want);
    checks++;
    a_value: assert (got === want)
      else begin
        errors++;
        $display("MISMATCH t=%0t %s exp=%0h got=%0h", $time, name, want, got);
      end
  endtask

  task automatic require(input logic cond, input string what);
    checks++;
    a_cond: assert (cond)
      else begin
        errors++;
        $display("ERROR t=%0t %s", $time, what);
      end
  endtask

  // IF/ID contents one cycle after a capture edge
  task automatic check_capture(input stim_t s, input logic [31:0] pc,
                               input if_id_pipe_t last);
    logic c_zone;
    logic e_zone;
    c_zone = (pc >= 32'h0000_2000) && (pc < 32'h0000_3000);
    e_zone = (pc >= 32'h0000_3000) && (pc < 32'h0000_3100);
    compare_value("pipe_o.instr_valid", pipe.instr_valid, 1'b1);
    compare_value("pipe_o.priv_lvl", pipe.priv_lvl, PRIV_LVL_M);
    if (s.pc_mux == TRAP_CLICV) begin
      // Pointer entry leaves pc and word alone
      compare_value("pipe_o.clic_ptr", pipe.clic_ptr, 1'b1);
      compare_value("pipe_o.ptr", pipe.ptr, 32'h0000_2000 + {24'd0, s.mtvt_idx, 4'h0});
      compare_value("pipe_o.bus_err", pipe.bus_err, 1'b0);
      compare_value("pipe_o.pc", pipe.pc, last.pc);
      compare_value("pipe_o.word", pipe.word, last.word);
      // Only the pointer read was issued, so the bus is idle now
      compare_value("busy_o", busy, 1'b0);
      compare_value("arvalid_o", arvalid, 1'b0);
      compare_value("if_valid_o", if_valid, 1'b0);
    end else begin
      compare_value("pipe_o.pc", pipe.pc, pc);
      compare_value("pipe_o.word", pipe.word, exp_word(pc));
      compare_value("pipe_o.clic_ptr", pipe.clic_ptr, 1'b0);
      compare_value("pipe_o.bus_err", pipe.bus_err, e_zone);
      compare_value("pipe_o.compressed", pipe.compressed, c_zone);
      compare_value("pipe_o.illegal_c", pipe.illegal_c, pc == 32'h0000_2100);
    end
  endtask

  // Redirect, then follow the captured stream until n_words arrived
  task automatic run_entry(input stim_t s);
    logic        cap;
    logic        held;
    if_id_pipe_t last;
    int          got;
    int          cyc;
    logic [31:0] exp_pc;
    exp_pc = first_pc(s);
    if (s.pc_mux == TRAP_CLICV) begin
      ptr_idx = s.mtvt_idx;
    end
    @(posedge clk);
    ctrl    <= make_ctrl(s, 1'b1);
    targets <= make_targets(s);
    @(negedge clk);
    compare_value("mtvec_init_o", mtvec_init, s.pc_mux == BOOT);
    if (busy) begin
      busy_redirects++;
    end
    last = pipe;
    // Redirect cycle is killed, only back-pressure can hold the register
    cap  = 1'b0;
    held = !id_ready;
    got  = 0;
    cyc  = 0;
    while (got < int'(s.n_words)) begin
      @(posedge clk);
      ctrl <= make_ctrl(s, 1'b0);
      if (s.ready_pat == 8'h00) begin
        id_ready <= ({$random(seed)} % 4) != 0;
      end else begin
        id_ready <= s.ready_pat[cyc % 8];
      end
      cyc++;
      @(negedge clk);
      compare_value("mtvec_init_o", mtvec_init, 1'b0);
      if (cap) begin
        check_capture(s, exp_pc, last);
        exp_pc += 32'd4;
        got++;
      end else if (held) begin
        // Back-pressure freezes the whole register
        compare_value("pipe_o", pipe, last);
      end else begin
        // ID ready without a word gives a bubble
        compare_value("pipe_o.instr_valid", pipe.instr_valid, 1'b0);
      end
      if (if_valid && got < int'(s.n_words)) begin
        compare_value("pc_if_o", pc_if, exp_pc);
      end
      // Privileged instruction access
      if (arvalid) begin
        compare_value("ar_o.arprot", ar.arprot, 3'b101);
      end
      // R channel is never stalled
      compare_value("rready_o", rready, 1'b1);
      last = pipe;
      cap  = if_valid && id_ready;
      held = !id_ready;
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n    = 1'b0;
    ctrl     = '0;
    targets  = '0;
    id_ready = 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    // Stage stays idle until the first redirect
    repeat (3) @(negedge clk);
    compare_value("arvalid_o", arvalid, 1'b0);
    compare_value("if_valid_o", if_valid, 1'b0);
    compare_value("busy_o", busy, 1'b0);
    compare_value("mtvec_init_o", mtvec_init, 1'b0);
    compare_value("pipe_o.instr_valid", pipe.instr_valid, 1'b0);
    compare_value("pipe_o.priv_lvl", pipe.priv_lvl, PRIV_LVL_M);
    foreach (stim[i]) begin
      run_entry(stim[i]);
    end
    require(busy_redirects > 0, "no redirect happened while reads were in flight");
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Budget of 40 cycles per expected word
  initial begin : watchdog
    int limit;
    limit = 0;
    foreach (stim[i]) begin
      limit += 40 * int'(stim[i].n_words);
    end
    #(limit * 20);
    $display("Timeout after %0d cycles, the stage stopped delivering words", limit);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== tb_axi_mem.sv ====
/*
  AXI4-Lite read slave model for the fetch stage testbench
  Answers in order, arready and rvalid come after 0 to 3 random idle cycles
  Memory content follows fixed address rules, no storage
  Holds at most the reads the master has outstanding
*/
`timescale 1ns/10ps

module tb_axi_mem #(
  parameter int SEED = 32'h67d50821
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  axi_lite_pkg::axi_ar_t ar_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  output axi_lite_pkg::axi_r_t  r_o,
  output logic                  rvalid_o,
  input  logic                  rready_i
);

  import axi_lite_pkg::*;

  integer      seed = SEED;
  logic [31:0] pend_q [$];
  int          ar_wait;
  int          r_wait;

  // Data and response for one address
  function automatic axi_r_t read_beat(logic [31:0] a);
    axi_r_t b;
    b.rresp = RESP_OKAY;
    b.rdata = a ^ 32'h5A5A_0003;
    if (a >= 32'h0000_4000 && a < 32'h0000_4040) begin
      // CLIC vector table, entry k points to 0x2000 + 16k
      b.rdata = 32'h0000_2001 + ((a - 32'h0000_4000) << 2);
    end else if (a >= 32'h0000_3000 && a < 32'h0000_3100) begin
      b.rresp = RESP_SLVERR;
      b.rdata = '0;
    end else if (a == 32'h0000_2100) begin
      // Illegal compressed instruction
      b.rdata[15:0] = 16'h0000;
    end else if (a >= 32'h0000_2000 && a < 32'h0000_3000) begin
      b.rdata[1:0] = 2'b01;
    end
    return b;
  endfunction

  initial begin
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    r_o       = '0;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      r_o       <= '0;
      pend_q.delete();
      ar_wait = 0;
      r_wait  = 0;
    end else begin
      // Address channel
      if (arvalid_i && arready_o) begin
        pend_q.push_back(ar_i.araddr);
        arready_o <= 1'b0;
        ar_wait = {$random(seed)} % 4;
      end else if (arvalid_i) begin
        if (ar_wait == 0) begin
          arready_o <= 1'b1;
        end else begin
          ar_wait--;
        end
      end
      // Data channel, oldest read first
      if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
        r_wait = {$random(seed)} % 4;
      end else if (!rvalid_o && pend_q.size() != 0) begin
        if (r_wait == 0) begin
          rvalid_o <= 1'b1;
          r_o      <= read_beat(pend_q.pop_front());
        end else begin
          r_wait--;
        end
      end
    end
  end

endmodule

// ==== if_stage_top.sv ====
/*
  Instruction fetch stage top level
  AXI4-Lite read master only, write channels absent
  Fetching starts after the first pc_set
*/
`timescale 1ns/10ps

module if_stage_top (
  input  logic                  clk,
  input  logic                  rst_n,

  // Controller
  input  if_pkg::ctrl_fsm_t     ctrl_i,
  input  if_pkg::pc_targets_t   targets_i,

  // AXI4-Lite read channels
  output axi_lite_pkg::axi_ar_t ar_o,
  output logic                  arvalid_o,
  input  logic                  arready_i,
  input  axi_lite_pkg::axi_r_t  r_i,
  input  logic                  rvalid_i,
  output logic                  rready_o,

  // ID stage
  input  logic                  id_ready_i,
  output logic                  if_valid_o,
  output if_pkg::if_id_pipe_t   pipe_o,
  output logic [31:0]           pc_if_o,

  output logic                  mtvec_init_o,
  output logic                  busy_o
);

  import if_pkg::*;

  logic [31:0] branch_addr;
  logic        fetch_valid;
  logic        fetch_ready;
  fetch_resp_t fetch_resp;

  // Redirect target
  pc_target_sel pc_target_sel_i (
    .ctrl_i        ( ctrl_i       ),
    .targets_i     ( targets_i    ),
    .pipe_ptr_i    ( pipe_o.ptr   ),
    .branch_addr_o ( branch_addr  ),
    .mtvec_init_o  ( mtvec_init_o )
  );

  // Bus reads and response buffering
  fetch_unit fetch_unit_i (
    .clk           ( clk          ),
    .rst_n         ( rst_n        ),
    .ctrl_i        ( ctrl_i       ),
    .branch_addr_i ( branch_addr  ),
    .ar_o          ( ar_o         ),
    .arvalid_o     ( arvalid_o    ),
    .arready_i     ( arready_i    ),
    .r_i           ( r_i          ),
    .rvalid_i      ( rvalid_i     ),
    .rready_o      ( rready_o     ),
    .ready_i       ( fetch_ready  ),
    .valid_o       ( fetch_valid  ),
    .resp_o        ( fetch_resp   ),
    .busy_o        ( busy_o       )
  );

  // PC of the word at the buffer head
  assign pc_if_o = fetch_resp.pc;

  // Predecode and IF/ID register
  if_id_pipe if_id_pipe_i (
    .clk           ( clk          ),
    .rst_n         ( rst_n        ),
    .ctrl_i        ( ctrl_i       ),
    .valid_i       ( fetch_valid  ),
    .resp_i        ( fetch_resp   ),
    .id_ready_i    ( id_ready_i   ),
    .ready_o       ( fetch_ready  ),
    .if_valid_o    ( if_valid_o   ),
    .pipe_o        ( pipe_o       )
  );

endmodule

// ==== if_id_pipe.sv ====
/*
  Predecode and IF/ID pipeline register
  No compressed expander, only flags are derived
  A pointer word updates ptr, bus_err and clic_ptr only
  Register freezes while ID is not ready
*/
`timescale 1ns/10ps

module if_id_pipe (
  input  logic                clk,
  input  logic                rst_n,
  input  if_pkg::ctrl_fsm_t   ctrl_i,
  input  logic                valid_i,
  input  if_pkg::fetch_resp_t resp_i,
  input  logic                id_ready_i,
  output logic                ready_o,
  output logic                if_valid_o,
  output if_pkg::if_id_pipe_t pipe_o
);

  import if_pkg::*;

  logic compressed;
  logic illegal_c;

  // Killed words are consumed, halted ones wait
  assign ready_o    = ctrl_i.kill_if || (id_ready_i && !ctrl_i.halt_if);
  assign if_valid_o = valid_i && !ctrl_i.kill_if && !ctrl_i.halt_if;

  ////////////////////////////////////////////////////////////////////////////
  // Predecode
  ////////////////////////////////////////////////////////////////////////////

  // Low two bits other than 11 mark a compressed instruction
  // Faulted fetches carry no usable flags
  assign compressed = (resp_i.word.instr.compressed[1:0] != 2'b11) && !resp_i.err;

  // All-zero compressed half is the defined illegal instruction
  assign illegal_c  = compressed && (resp_i.word.instr.compressed == 16'h0000);

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pipe_o.instr_valid <= 1'b0;
      pipe_o.pc          <= '0;
      pipe_o.word        <= '0;
      pipe_o.compressed  <= 1'b0;
      pipe_o.illegal_c   <= 1'b0;
      pipe_o.bus_err     <= 1'b0;
      pipe_o.clic_ptr    <= 1'b0;
      pipe_o.ptr         <= '0;
      pipe_o.priv_lvl    <= PRIV_LVL_M;
    end else if (if_valid_o && id_ready_i) begin
      pipe_o.instr_valid <= 1'b1;
      pipe_o.bus_err     <= resp_i.err;
      pipe_o.clic_ptr    <= resp_i.is_ptr;
      // Fetches run in machine mode
      pipe_o.priv_lvl    <= PRIV_LVL_M;
      if (resp_i.is_ptr) begin
        // Handler address, bit 0 cleared as for any jump target
        pipe_o.ptr <= {resp_i.word.ptr[31:1], 1'b0};
      end else begin
        pipe_o.pc         <= resp_i.pc;
        pipe_o.word       <= resp_i.word;
        pipe_o.compressed <= compressed;
        pipe_o.illegal_c  <= illegal_c;
      end
    end else if (id_ready_i) begin
      // Bubble into ID
      pipe_o.instr_valid <= 1'b0;
    end
  end

endmodule

// ==== fetch_unit.sv ====
/*
  Word fetcher with an AXI4-Lite read master
  Up to FETCH_DEPTH reads in flight, counted together with buffered words
  R data returns in order, rready is always high
  Stale beats after a redirect are counted off and dropped
*/
`timescale 1ns/10ps

module fetch_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  if_pkg::ctrl_fsm_t     ctrl_i,
  input  logic [31:0]           branch_addr_i,
  output axi_lite_pkg::axi_ar_t ar_o,
  output logic                  arvalid_o,
  input  logic                  arready_i,
  input  axi_lite_pkg::axi_r_t  r_i,
  input  logic                  rvalid_i,
  output logic                  rready_o,
  input  logic                  ready_i,
  output logic                  valid_o,
  output if_pkg::fetch_resp_t   resp_o,
  output logic                  busy_o
);

  import if_pkg::*;
  import axi_lite_pkg::*;

  // Fetch PC and request side
  logic [31:0]            fetch_pc_q;
  logic                   fetch_en_q;
  logic                   ptr_q;
  logic                   arvalid_q;
  logic [31:0]            araddr_q;

  // Response side
  logic [31:0]            resp_pc_q;
  logic [FETCH_CNT_W-1:0] inflight_q;
  logic [FETCH_CNT_W-1:0] drop_q;

  logic                   r_fire;
  logic                   push;
  logic                   pop;
  logic                   ar_free;
  logic                   credit_ok;
  logic                   issue_en;
  logic                   issue_ptr;
  logic                   issue;
  logic [31:0]            issue_addr;
  logic [FETCH_CNT_W:0]   occupied;
  logic [FETCH_CNT_W-1:0] fifo_cnt;
  fetch_resp_t            push_data;

  ////////////////////////////////////////////////////////////////////////////
  // Read issue
  ////////////////////////////////////////////////////////////////////////////

  // A redirect issues straight from the new target
  assign issue_en   = ctrl_i.pc_set || fetch_en_q;
  assign issue_addr = ctrl_i.pc_set ? branch_addr_i : fetch_pc_q;
  assign issue_ptr  = ctrl_i.pc_set ? (ctrl_i.pc_mux == TRAP_CLICV) : ptr_q;

  // AR slot is free when idle or accepted this cycle
  assign ar_free = !arvalid_q || arready_i;

  // Reads in flight plus words left in the buffer after this cycle
  always_comb begin
    occupied = {1'b0, inflight_q};
    if (!ctrl_i.pc_set) begin
      occupied = occupied + {1'b0, fifo_cnt} - (FETCH_CNT_W + 1)'(pop);
    end
  end

  assign credit_ok = (occupied < (FETCH_CNT_W + 1)'(FETCH_DEPTH));
  assign issue     = issue_en && ar_free && credit_ok;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_pc_q <= '0;
      fetch_en_q <= 1'b0;
      ptr_q      <= 1'b0;
      arvalid_q  <= 1'b0;
    end else begin
      if (issue) begin
        fetch_pc_q <= {issue_addr[31:2], 2'b00} + 32'd4;
      end else if (ctrl_i.pc_set) begin
        fetch_pc_q <= branch_addr_i;
      end

      if (ctrl_i.pc_set) begin
        ptr_q <= issue_ptr;
      end

      // Pointer fetch is a single read
      if (issue && issue_ptr) begin
        fetch_en_q <= 1'b0;
      end else if (ctrl_i.pc_set) begin
        fetch_en_q <= 1'b1;
      end

      if (issue) begin
        arvalid_q <= 1'b1;
      end else if (arready_i) begin
        arvalid_q <= 1'b0;
      end
    end
  end

  // Address held until accepted
  always_ff @(posedge clk) begin
    if (issue) begin
      araddr_q <= {issue_addr[31:2], 2'b00};
    end
  end

  // Machine mode instruction access
  assign ar_o.araddr = araddr_q;
  assign ar_o.arprot = ARPROT_INSTR | ARPROT_PRIV;
  assign arvalid_o   = arvalid_q;

  ////////////////////////////////////////////////////////////////////////////
  // Responses
  ////////////////////////////////////////////////////////////////////////////

  assign rready_o = 1'b1;
  assign r_fire   = rvalid_i && rready_o;

  // Beats of the old stream never reach the buffer
  assign push = r_fire && (drop_q == '0) && !ctrl_i.pc_set;
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_pc_q  <= '0;
      inflight_q <= '0;
      drop_q     <= '0;
    end else begin
      inflight_q <= inflight_q + FETCH_CNT_W'(issue) - FETCH_CNT_W'(r_fire);
      if (ctrl_i.pc_set) begin
        // Everything still out belongs to the old stream
        resp_pc_q <= {branch_addr_i[31:2], 2'b00};
        drop_q    <= inflight_q - FETCH_CNT_W'(r_fire);
      end else begin
        if (push) begin
          resp_pc_q <= resp_pc_q + 32'd4;
        end
        if (r_fire && (drop_q != '0)) begin
          drop_q <= drop_q - 1'b1;
        end
      end
    end
  end

  // Tag word with PC, error status and pointer flag
  assign push_data.pc     = resp_pc_q;
  assign push_data.word   = r_i.rdata;
  assign push_data.err    = (r_i.rresp != RESP_OKAY);
  assign push_data.is_ptr = ptr_q;

  resp_fifo resp_fifo_i (
    .clk         ( clk             ),
    .rst_n       ( rst_n           ),
    .flush_i     ( ctrl_i.pc_set   ),
    .push_i      ( push            ),
    .push_data_i ( push_data       ),
    .pop_i       ( pop             ),
    .valid_o     ( valid_o         ),
    .head_o      ( resp_o          ),
    .count_o     ( fifo_cnt        )
  );

  assign busy_o = (inflight_q != '0);

  // AXI rule for a pending request
  a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o.araddr))
    else $error("araddr changed while AR pending");

  // Slave only answers reads that were issued
  a_r_expected: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> (inflight_q != '0))
    else $error("R beat without a read in flight");

endmodule

// ==== resp_fifo.sv ====
/*
  Response buffer of FETCH_DEPTH entries
  Flush wins over push and pop in the same cycle
  Caller must not push when full or pop when empty
*/
`timescale 1ns/10ps

module resp_fifo (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            flush_i,
  input  logic                            push_i,
  input  if_pkg::fetch_resp_t             push_data_i,
  input  logic                            pop_i,
  output logic                            valid_o,
  output if_pkg::fetch_resp_t             head_o,
  output logic [if_pkg::FETCH_CNT_W-1:0]  count_o
);

  import if_pkg::*;

  localparam logic [FETCH_PTR_W-1:0] LAST_IDX = FETCH_PTR_W'(FETCH_DEPTH - 1);

  fetch_resp_t            mem_q [FETCH_DEPTH];
  logic [FETCH_PTR_W-1:0] wr_ptr_q;
  logic [FETCH_PTR_W-1:0] rd_ptr_q;
  logic [FETCH_CNT_W-1:0] cnt_q;
  logic                   do_push;
  logic                   do_pop;

  // Ignore push and pop while flushing
  assign do_push = push_i && !flush_i;
  assign do_pop  = pop_i && !flush_i;

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_IDX) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_IDX) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + FETCH_CNT_W'(do_push) - FETCH_CNT_W'(do_pop);
    end
  end

  assign valid_o = (cnt_q != '0);
  assign head_o  = mem_q[rd_ptr_q];
  assign count_o = cnt_q;

  // Fetch credits keep the buffer from overflowing
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    do_push |-> (cnt_q < FETCH_CNT_W'(FETCH_DEPTH)))
    else $error("push into full response buffer");

  // Consumer only pops a valid head
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    do_pop |-> valid_o)
    else $error("pop from empty response buffer");

endmodule

// ==== pc_target_sel.sv ====
/*
  Fetch target mux, purely combinational
  Boot and debug targets are forced to word alignment
  Vectored targets are base plus index times 4
  Bit 0 of the result is always cleared
*/
`timescale 1ns/10ps

module pc_target_sel (
  input  if_pkg::ctrl_fsm_t   ctrl_i,
  input  if_pkg::pc_targets_t targets_i,
  input  logic [31:0]         pipe_ptr_i,
  output logic [31:0]         branch_addr_o,
  output logic                mtvec_init_o
);

  import if_pkg::*;

  logic [31:0] addr_sel;

  always_comb begin
    // Boot address unless a source says otherwise
    addr_sel = {targets_i.boot[31:2], 2'b00};

    case (ctrl_i.pc_mux)
      BOOT:       addr_sel = {targets_i.boot[31:2], 2'b00};
      JUMP:       addr_sel = targets_i.jump;
      BRANCH:     addr_sel = targets_i.branch;
      // Return from trap or debug
      MRET:       addr_sel = targets_i.mepc;
      DRET:       addr_sel = targets_i.dpc;
      // Exceptions share the base address
      TRAP_EXC:   addr_sel = {targets_i.mtvec, 7'h00};
      // Interrupts are vectored
      TRAP_IRQ:   addr_sel = {targets_i.mtvec, ctrl_i.mtvec_idx, 2'b00};
      TRAP_NMI:   addr_sel = {targets_i.mtvec, NMI_MTVEC_INDEX, 2'b00};
      TRAP_DBD:   addr_sel = {targets_i.dm_halt[31:2], 2'b00};
      TRAP_DBE:   addr_sel = {targets_i.dm_exc[31:2], 2'b00};
      // Vector table entry holding the handler pointer
      TRAP_CLICV: addr_sel = {targets_i.mtvt, ctrl_i.mtvt_idx, 2'b00};
      // Pointer captured in IF/ID
      POINTER:    addr_sel = pipe_ptr_i;
      default:    ;
    endcase
  end

  assign branch_addr_o = {addr_sel[31:1], 1'b0};

  // CSR file loads mtvec on boot
  assign mtvec_init_o = ctrl_i.pc_set && (ctrl_i.pc_mux == BOOT);

  // Controller only redirects through a defined source
  always_comb begin
    if (ctrl_i.pc_set) begin
      a_pc_mux_known: assert (!$isunknown(ctrl_i.pc_mux) && (ctrl_i.pc_mux <= POINTER))
        else $error("pc_set with undefined pc_mux %0d", ctrl_i.pc_mux);
    end
  end

endmodule

// ==== axi_lite_pkg.sv ====
/*
  AXI4-Lite read channel types
  Only the read side is described
  Write channels are not used by the fetch stage
*/

package axi_lite_pkg;

  // Read response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // arprot bits
  localparam logic [2:0] ARPROT_PRIV  = 3'b001;
  localparam logic [2:0] ARPROT_INSTR = 3'b100;

  // Read address channel
  typedef struct packed {
    logic [31:0] araddr;
    logic [2:0]  arprot;
  } axi_ar_t;

  // Read data channel
  typedef struct packed {
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axi_r_t;

endpackage

// ==== if_pkg.sv ====
/*
  Types and constants of the instruction fetch stage
  Fetches are aligned 32-bit words
  A compressed instruction sits in the low half of its word
  The core runs in machine mode only
*/

package if_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Fetch constants
  ////////////////////////////////////////////////////////////////////////////

  // Width of the CLIC vector table base address
  localparam int unsigned MTVT_ADDR_W = 26;

  // mtvec slot used by the NMI
  localparam logic [4:0]  NMI_MTVEC_INDEX = 5'd15;

  // Reads in flight and response buffer entries
  localparam int unsigned FETCH_DEPTH = 2;
  localparam int unsigned FETCH_CNT_W = $clog2(FETCH_DEPTH + 1);
  localparam int unsigned FETCH_PTR_W = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1;

  // Machine mode privilege encoding
  localparam logic [1:0]  PRIV_LVL_M = 2'b11;

  ////////////////////////////////////////////////////////////////////////////
  // Controller interface
  ////////////////////////////////////////////////////////////////////////////

  // Program counter source
  typedef enum logic [3:0] {
    BOOT,
    JUMP,
    BRANCH,
    MRET,
    DRET,
    TRAP_EXC,
    TRAP_IRQ,
    TRAP_NMI,
    TRAP_DBD,
    TRAP_DBE,
    TRAP_CLICV,
    POINTER
  } pc_mux_e;

  // Controller commands to IF
  typedef struct packed {
    logic       pc_set;
    pc_mux_e    pc_mux;
    logic       kill_if;
    logic       halt_if;
    logic [4:0] mtvec_idx;
    logic [3:0] mtvt_idx;
  } ctrl_fsm_t;

  // Redirect addresses
  typedef struct packed {
    logic [31:0]            boot;
    logic [31:0]            jump;
    logic [31:0]            branch;
    logic [31:0]            mepc;
    logic [31:0]            dpc;
    logic [31:0]            dm_halt;
    logic [31:0]            dm_exc;
    logic [24:0]            mtvec;
    logic [MTVT_ADDR_W-1:0] mtvt;
  } pc_targets_t;

  ////////////////////////////////////////////////////////////////////////////
  // Fetched data
  ////////////////////////////////////////////////////////////////////////////

  // Instruction halves
  typedef struct packed {
    logic [15:0] upper;
    logic [15:0] compressed;
  } instr_word_t;

  // One fetched word, decoded as instruction or as CLIC pointer
  typedef union packed {
    instr_word_t instr;
    logic [31:0] ptr;
  } fetch_word_u;

  // Response buffer entry
  typedef struct packed {
    logic [31:0] pc;
    fetch_word_u word;
    logic        err;
    logic        is_ptr;
  } fetch_resp_t;

  // IF/ID pipeline register
  typedef struct packed {
    logic        instr_valid;
    logic [31:0] pc;
    fetch_word_u word;
    logic        compressed;
    logic        illegal_c;
    logic        bus_err;
    logic        clic_ptr;
    logic [31:0] ptr;
    logic [1:0]  priv_lvl;
  } if_id_pipe_t;

endpackage
